// ==== verilog/mmu_defines.svh ====
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

////////////////////
// TLB geometry
`define TLB_ENTRIES 16
`define TLB_IDX_W 4

// field widths
`define VPN2_W 19
`define ASID_W 8
`define PFN_W 20
`define CACHE_W 3
`define PAGE_OFS_W 12

////////////////////
// kseg0/kseg1 bypass the TLB
`define KSEG_UNMAPPED 2'b10

// physical windows
`define ROM_FRAME 20'h1FC00
`define SERIAL_ADDR0 32'h1FD003F8
`define SERIAL_ADDR1 32'h1FD003FC
`define FLASH_TOP 8'h1E

`endif

// ==== verilog/mmuTlbPkg.sv ====
package mmuTlbPkg;

	`include "mmu_defines.svh"

	typedef logic [`TLB_IDX_W-1:0] tlbIdx_t;

	// one page of an even/odd pair
	typedef struct packed {
		logic [`PFN_W-1:0] pfn;
		logic [`CACHE_W-1:0] cache;
		logic dirty;
		logic valid;
	} pageMap_t;

	typedef struct packed {
		logic present;
		logic [`VPN2_W-1:0] vpn2;
		logic [`ASID_W-1:0] asid;
		logic isGlobal;
		pageMap_t page0;
		pageMap_t page1;
	} tlbEntry_t;

	////////////////////
	// CP0 register layouts
	typedef struct packed {
		logic [`VPN2_W-1:0] vpn2;
		logic [32-`VPN2_W-`ASID_W-1:0] rsvd;
		logic [`ASID_W-1:0] asid;
	} entryHi_t;

	typedef struct packed {
		logic [32-`PFN_W-`CACHE_W-3-1:0] rsvd;
		logic [`PFN_W-1:0] pfn;
		logic [`CACHE_W-1:0] cache;
		logic dirty;
		logic valid;
		logic isGlobal;
	} entryLo_t;

	typedef struct packed {
		entryHi_t entryHi;
		entryLo_t entryLo0;
		entryLo_t entryLo1;
		logic [31:0] index;
		logic [31:0] random;
	} cp0TlbRegs_t;

	typedef struct packed {
		logic valid;
		entryHi_t entryHi;
		entryLo_t entryLo0;
		entryLo_t entryLo1;
	} tlbReadOut_t;

endpackage

// ==== verilog/mmuXlatPkg.sv ====
package mmuXlatPkg;

	`include "mmu_defines.svh"

	typedef struct packed {
		logic valid;
		logic [31:0] vaddr;
		logic write;
	} xlatReq_t;

	// refill is the plain miss case
	typedef enum logic [1:0] {
		FAULT_NONE,
		FAULT_REFILL,
		FAULT_INVALID,
		FAULT_MODIFIED
	} xlatFault_t;

	typedef enum logic [2:0] {
		REGION_SRAM,
		REGION_ROM,
		REGION_SERIAL,
		REGION_FLASH,
		REGION_NONE
	} memRegion_t;

	typedef struct packed {
		logic valid;
		logic [31:0] paddr;
		xlatFault_t fault;
		memRegion_t region;
		logic [`ASID_W-1:0] asid;
	} xlatResp_t;

endpackage

// ==== verilog/physRegionDecode.sv ====
`include "mmu_defines.svh"

module physRegionDecode (
	input logic [31:0] paddr_i,
	output mmuXlatPkg::memRegion_t region_o
);

	import mmuXlatPkg::*;

	// first match wins
	always_comb
	begin
		if (paddr_i[31:28] == 4'h0)
		begin
			region_o = REGION_SRAM;
		end
		else if (paddr_i[31:12] == `ROM_FRAME)
		begin
			region_o = REGION_ROM;
		end
		else if ((paddr_i == `SERIAL_ADDR0) || (paddr_i == `SERIAL_ADDR1))
		begin
			region_o = REGION_SERIAL;
		end
		else if (paddr_i[31:24] == `FLASH_TOP)
		begin
			region_o = REGION_FLASH;
		end
		else
		begin
			region_o = REGION_NONE;
		end
	end

endmodule

// ==== verilog/tlbMatch.sv ====
`include "mmu_defines.svh"

module tlbMatch (
	input mmuTlbPkg::tlbEntry_t [`TLB_ENTRIES-1:0] table_i,
	input logic [`VPN2_W-1:0] vpn2_i,
	input logic [`ASID_W-1:0] asid_i,
	output logic [`TLB_ENTRIES-1:0] hitVec_o,
	output logic hit_o,
	output mmuTlbPkg::tlbIdx_t hitIdx_o
);

	import mmuTlbPkg::*;

	// global entries ignore the ASID
	always_comb
	begin
		for (int i = 0; i < `TLB_ENTRIES; i++)
		begin
			hitVec_o[i] = table_i[i].present
				&& (table_i[i].vpn2 == vpn2_i)
				&& (table_i[i].isGlobal || (table_i[i].asid == asid_i));
		end
	end

	assign hit_o = |hitVec_o;

	// highest slot wins
	always_comb
	begin
		hitIdx_o = '0;
		for (int i = 0; i < `TLB_ENTRIES; i++)
		begin
			if (hitVec_o[i])
			begin
				hitIdx_o = tlbIdx_t'(i);
			end
		end
	end

endmodule

// ==== verilog/tlbStore.sv ====
`include "mmu_defines.svh"

module tlbStore (
	input logic clk,
	input logic rstN_i,
	input mmuTlbPkg::cp0TlbRegs_t cp0Regs_i,
	input logic tlbrStrobe_i,
	input logic wrEn_i,
	input mmuTlbPkg::tlbIdx_t wrIdx_i,
	input mmuTlbPkg::tlbEntry_t wrEntry_i,
	output mmuTlbPkg::tlbEntry_t [`TLB_ENTRIES-1:0] table_o,
	output mmuTlbPkg::tlbReadOut_t tlbrData_o
);

	import mmuTlbPkg::*;

	tlbEntry_t [`TLB_ENTRIES-1:0] entries;
	tlbEntry_t rdEntry;
	logic rdValid;
	entryHi_t rdHi;
	entryLo_t rdLo0;
	entryLo_t rdLo1;

	function automatic entryLo_t toEntryLo(pageMap_t page, logic isGlobal);
		entryLo_t lo;
		lo = '0;
		lo.pfn = page.pfn;
		lo.cache = page.cache;
		lo.dirty = page.dirty;
		lo.valid = page.valid;
		lo.isGlobal = isGlobal;
		return lo;
	endfunction

	////////////////////
	// entry array
	always_ff @(posedge clk or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			entries <= '0;
		end
		else if (wrEn_i)
		begin
			entries[wrIdx_i] <= wrEntry_i;
		end
	end

	assign table_o = entries;

	////////////////////
	// tlbr read-out
	assign rdEntry = entries[cp0Regs_i.index[`TLB_IDX_W-1:0]];

	always_ff @(posedge clk or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			rdValid <= 1'b0;
		end
		else
		begin
			rdValid <= tlbrStrobe_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (tlbrStrobe_i)
		begin
			rdHi <= '{vpn2: rdEntry.vpn2, rsvd: '0, asid: rdEntry.asid};
			rdLo0 <= toEntryLo(rdEntry.page0, rdEntry.isGlobal);
			rdLo1 <= toEntryLo(rdEntry.page1, rdEntry.isGlobal);
		end
	end

	assign tlbrData_o = '{valid: rdValid, entryHi: rdHi, entryLo0: rdLo0, entryLo1: rdLo1};

endmodule

// ==== verilog/tlbWriteCtrl.sv ====
`include "mmu_defines.svh"

module tlbWriteCtrl (
	input logic clk,
	input logic rstN_i,
	input mmuTlbPkg::cp0TlbRegs_t cp0Regs_i,
	input logic tlbwStrobe_i,
	input logic tlbwRandom_i,
	input logic [`TLB_ENTRIES-1:0] dupHitVec_i,
	output logic wrEn_o,
	output mmuTlbPkg::tlbIdx_t wrIdx_o,
	output mmuTlbPkg::tlbEntry_t wrEntry_o,
	output logic mcheck_o
);

	import mmuTlbPkg::*;

	tlbIdx_t slot;
	tlbIdx_t slotQ;
	tlbEntry_t newEntry;
	tlbEntry_t entryQ;
	logic [`TLB_ENTRIES-1:0] otherHits;
	logic pending;
	logic dupQ;

	function automatic pageMap_t toPage(entryLo_t lo);
		return '{pfn: lo.pfn, cache: lo.cache, dirty: lo.dirty, valid: lo.valid};
	endfunction

	assign slot = tlbwRandom_i ? cp0Regs_i.random[`TLB_IDX_W-1:0]
		: cp0Regs_i.index[`TLB_IDX_W-1:0];

	// a hit on the target slot itself is not a duplicate
	always_comb
	begin
		otherHits = dupHitVec_i;
		otherHits[slot] = 1'b0;
	end

	always_comb
	begin
		newEntry.present = 1'b1;
		newEntry.vpn2 = cp0Regs_i.entryHi.vpn2;
		newEntry.asid = cp0Regs_i.entryHi.asid;
		newEntry.isGlobal = cp0Regs_i.entryLo0.isGlobal & cp0Regs_i.entryLo1.isGlobal;
		newEntry.page0 = toPage(cp0Regs_i.entryLo0);
		newEntry.page1 = toPage(cp0Regs_i.entryLo1);
	end

	always_ff @(posedge clk or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			pending <= 1'b0;
			dupQ <= 1'b0;
			mcheck_o <= 1'b0;
		end
		else
		begin
			pending <= tlbwStrobe_i;
			dupQ <= tlbwStrobe_i && (|otherHits);
			mcheck_o <= pending && dupQ;
		end
	end

	always_ff @(posedge clk)
	begin
		if (tlbwStrobe_i)
		begin
			slotQ <= slot;
			entryQ <= newEntry;
		end
	end

	// commit on the second cycle
	assign wrEn_o = pending && !dupQ;
	assign wrIdx_o = slotQ;
	assign wrEntry_o = entryQ;

endmodule

// ==== verilog/addrTranslate.sv ====
`include "mmu_defines.svh"

module addrTranslate (
	input logic clk,
	input logic rstN_i,
	input mmuXlatPkg::xlatReq_t xlatReq_i,
	input mmuTlbPkg::tlbEntry_t [`TLB_ENTRIES-1:0] table_i,
	input logic hit_i,
	input mmuTlbPkg::tlbIdx_t hitIdx_i,
	output mmuXlatPkg::xlatResp_t xlatResp_o
);

	import mmuTlbPkg::*;
	import mmuXlatPkg::*;

	logic s1Valid;
	logic [31:0] s1Vaddr;
	logic s1Write;
	logic s1Hit;
	tlbIdx_t s1HitIdx;
	logic s1Unmapped;

	tlbEntry_t s2Entry;
	pageMap_t s2Page;
	xlatFault_t s2Fault;
	logic [31:0] s2Paddr;
	memRegion_t s2Region;
	logic [`ASID_W-1:0] s2Asid;

	logic respValid;
	logic [31:0] respPaddr;
	xlatFault_t respFault;
	memRegion_t respRegion;
	logic [`ASID_W-1:0] respAsid;

	////////////////////
	// stage one
	always_ff @(posedge clk or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			s1Valid <= 1'b0;
		end
		else
		begin
			s1Valid <= xlatReq_i.valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (xlatReq_i.valid)
		begin
			s1Vaddr <= xlatReq_i.vaddr;
			s1Write <= xlatReq_i.write;
			s1Hit <= hit_i;
			s1HitIdx <= hitIdx_i;
			s1Unmapped <= (xlatReq_i.vaddr[31:30] == `KSEG_UNMAPPED);
		end
	end

	////////////////////
	// stage two
	assign s2Entry = table_i[s1HitIdx];
	// bit 12 picks the odd page
	assign s2Page = s1Vaddr[`PAGE_OFS_W] ? s2Entry.page1 : s2Entry.page0;

	always_comb
	begin
		if (s1Unmapped)
			s2Fault = FAULT_NONE;
		else if (!s1Hit)
			s2Fault = FAULT_REFILL;
		else if (!s2Page.valid)
			s2Fault = FAULT_INVALID;
		else if (s1Write && !s2Page.dirty)
			s2Fault = FAULT_MODIFIED;
		else
			s2Fault = FAULT_NONE;
	end

	always_comb
	begin
		if (s2Fault != FAULT_NONE)
			s2Paddr = '0;
		else if (s1Unmapped)
			s2Paddr = {3'b000, s1Vaddr[28:0]};
		else
			s2Paddr = {s2Page.pfn, s1Vaddr[`PAGE_OFS_W-1:0]};
	end

	assign s2Asid = (!s1Unmapped && s1Hit) ? s2Entry.asid : '0;

	physRegionDecode regionDec (
		.paddr_i(s2Paddr),
		.region_o(s2Region)
	);

	always_ff @(posedge clk or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			respValid <= 1'b0;
		end
		else
		begin
			respValid <= s1Valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (s1Valid)
		begin
			respPaddr <= s2Paddr;
			respFault <= s2Fault;
			respRegion <= s2Region;
			respAsid <= s2Asid;
		end
	end

	assign xlatResp_o = '{valid: respValid, paddr: respPaddr, fault: respFault,
		region: respRegion, asid: respAsid};

endmodule

// ==== verilog/mmuTop.sv ====
`include "mmu_defines.svh"

module mmuTop (
	input logic clk,
	input logic rstN_i,
	input mmuTlbPkg::cp0TlbRegs_t cp0Regs_i,
	input logic tlbwStrobe_i,
	input logic tlbwRandom_i,
	input logic tlbrStrobe_i,
	input mmuXlatPkg::xlatReq_t xlatReq_i,
	output mmuTlbPkg::tlbReadOut_t tlbrData_o,
	output logic mcheck_o,
	output mmuXlatPkg::xlatResp_t xlatResp_o
);

	import mmuTlbPkg::*;

	tlbEntry_t [`TLB_ENTRIES-1:0] tlbTable;
	logic [`TLB_ENTRIES-1:0] dupHitVec;
	logic lookupHit;
	tlbIdx_t lookupHitIdx;
	logic wrEn;
	tlbIdx_t wrIdx;
	tlbEntry_t wrEntry;

	tlbStore store (
		.clk(clk),
		.rstN_i(rstN_i),
		.cp0Regs_i(cp0Regs_i),
		.tlbrStrobe_i(tlbrStrobe_i),
		.wrEn_i(wrEn),
		.wrIdx_i(wrIdx),
		.wrEntry_i(wrEntry),
		.table_o(tlbTable),
		.tlbrData_o(tlbrData_o)
	);

	////////////////////
	// duplicate check against EntryHi
	tlbMatch dupMatch (
		.table_i(tlbTable),
		.vpn2_i(cp0Regs_i.entryHi.vpn2),
		.asid_i(cp0Regs_i.entryHi.asid),
		.hitVec_o(dupHitVec),
		.hit_o(),
		.hitIdx_o()
	);

	tlbWriteCtrl writeCtrl (
		.clk(clk),
		.rstN_i(rstN_i),
		.cp0Regs_i(cp0Regs_i),
		.tlbwStrobe_i(tlbwStrobe_i),
		.tlbwRandom_i(tlbwRandom_i),
		.dupHitVec_i(dupHitVec),
		.wrEn_o(wrEn),
		.wrIdx_o(wrIdx),
		.wrEntry_o(wrEntry),
		.mcheck_o(mcheck_o)
	);

	////////////////////
	// lookup uses the current ASID
	tlbMatch lookupMatch (
		.table_i(tlbTable),
		.vpn2_i(xlatReq_i.vaddr[31:32-`VPN2_W]),
		.asid_i(cp0Regs_i.entryHi.asid),
		.hitVec_o(),
		.hit_o(lookupHit),
		.hitIdx_o(lookupHitIdx)
	);

	addrTranslate xlat (
		.clk(clk),
		.rstN_i(rstN_i),
		.xlatReq_i(xlatReq_i),
		.table_i(tlbTable),
		.hit_i(lookupHit),
		.hitIdx_i(lookupHitIdx),
		.xlatResp_o(xlatResp_o)
	);

endmodule

// ==== test/mmuTop_sva.sv ====
module mmuTop_sva (
	input logic clk,
	input logic rstN_i,
	input logic tlbwStrobe_i,
	input logic tlbrStrobe_i,
	input mmuXlatPkg::xlatReq_t xlatReq_i,
	input mmuTlbPkg::tlbReadOut_t tlbrData_o,
	input logic mcheck_o,
	input mmuXlatPkg::xlatResp_t xlatResp_o
);

	timeunit 1ns;
	timeprecision 1ps;

	int violations = 0;

	////////////////////
	// translation latency
	respAfterReq: assert property (@(posedge clk) disable iff (!rstN_i)
		xlatReq_i.valid |-> ##2 xlatResp_o.valid)
	else
	begin
		$error("no translation response two cycles after a request");
		violations++;
	end

	respNeedsReq: assert property (@(posedge clk) disable iff (!rstN_i)
		xlatResp_o.valid |-> $past(xlatReq_i.valid, 2))
	else
	begin
		$error("translation response without a request two cycles earlier");
		violations++;
	end

	////////////////////
	// tlbr and machine check
	tlbrOneCycle: assert property (@(posedge clk) disable iff (!rstN_i)
		tlbrData_o.valid == $past(tlbrStrobe_i))
	else
	begin
		$error("tlbr data valid not one cycle after the tlbr strobe");
		violations++;
	end

	mcheckAfterWrite: assert property (@(posedge clk) disable iff (!rstN_i)
		mcheck_o |-> $past(tlbwStrobe_i, 2))
	else
	begin
		$error("machine check without a write strobe two cycles earlier");
		violations++;
	end

	// outputs held quiet while in reset
	quietInReset: assert property (@(posedge clk)
		!rstN_i |-> !xlatResp_o.valid && !tlbrData_o.valid && !mcheck_o)
	else
	begin
		$error("valid output high during reset");
		violations++;
	end

endmodule

bind mmuTop mmuTop_sva protocolChecks (.*);

// ==== test/mmuTop_tb.sv ====
`include "mmu_defines.svh"

module mmuTop_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import mmuTlbPkg::*;
	import mmuXlatPkg::*;

	// stimulus needs roughly a hundred cycles
	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic rstN_i;
	cp0TlbRegs_t cp0Regs_i;
	logic tlbwStrobe_i;
	logic tlbwRandom_i;
	logic tlbrStrobe_i;
	xlatReq_t xlatReq_i;
	tlbReadOut_t tlbrData_o;
	logic mcheck_o;
	xlatResp_t xlatResp_o;

	tlbEntry_t shadow [`TLB_ENTRIES];
	xlatResp_t respQ [$];
	logic [95:0] tlbrQ [$];
	xlatResp_t expResp;
	logic [95:0] expRd;
	logic [31:0] rngState;
	int cycleCount = 0;

	mmuTop i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic failRun();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		assert (actVal === expVal)
		else
		begin
			$display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expVal, actVal);
			failRun();
		end
	endtask

	function automatic logic [31:0] nextRand();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	////////////////////
	// reference model
	// EntryLo is six zero bits, PFN, C, D, V, G
	function automatic logic [31:0] encodeLo(pageMap_t p, logic g);
		return {6'b0, p.pfn, p.cache, p.dirty, p.valid, g};
	endfunction

	function automatic pageMap_t makePage(logic [`PFN_W-1:0] pfn, logic dirty, logic valid);
		pageMap_t p;
		p.pfn = pfn;
		p.cache = 3'd3;
		p.dirty = dirty;
		p.valid = valid;
		return p;
	endfunction

	function automatic memRegion_t regionOf(logic [31:0] pa);
		if (pa[31:28] == 4'h0)
			return REGION_SRAM;
		else if (pa[31:12] == `ROM_FRAME)
			return REGION_ROM;
		else if (pa == `SERIAL_ADDR0 || pa == `SERIAL_ADDR1)
			return REGION_SERIAL;
		else if (pa[31:24] == `FLASH_TOP)
			return REGION_FLASH;
		else
			return REGION_NONE;
	endfunction

	function automatic xlatResp_t expectXlat(logic [31:0] va, logic wr, logic [`ASID_W-1:0] asid);
		xlatResp_t r;
		pageMap_t p;
		int hitIdx;
		r = '0;
		r.valid = 1'b1;
		hitIdx = -1;
		if (va[31:30] == `KSEG_UNMAPPED)
			r.paddr = {3'b000, va[28:0]};
		else
		begin
			for (int i = 0; i < `TLB_ENTRIES; i++)
			begin
				if (shadow[i].present && shadow[i].vpn2 == va[31:13]
					&& (shadow[i].isGlobal || shadow[i].asid == asid))
					hitIdx = i;
			end
			if (hitIdx < 0)
				r.fault = FAULT_REFILL;
			else
			begin
				p = va[12] ? shadow[hitIdx].page1 : shadow[hitIdx].page0;
				r.asid = shadow[hitIdx].asid;
				if (!p.valid)
					r.fault = FAULT_INVALID;
				else if (wr && !p.dirty)
					r.fault = FAULT_MODIFIED;
				else
					r.paddr = {p.pfn, va[11:0]};
			end
		end
		r.region = regionOf(r.paddr);
		return r;
	endfunction

	////////////////////
	// stimulus tasks
	task automatic writeEntry(input logic useRandom, input int unsigned slot, input tlbEntry_t e);
		logic expDup;
		tlbEntry_t stored;
		expDup = 1'b0;
		stored = e;
		stored.present = 1'b1;
		for (int i = 0; i < `TLB_ENTRIES; i++)
		begin
			if (i != slot && shadow[i].present && shadow[i].vpn2 == e.vpn2
				&& (shadow[i].isGlobal || shadow[i].asid == e.asid))
				expDup = 1'b1;
		end
		@(posedge clk);
		cp0Regs_i.entryHi <= {e.vpn2, 5'b0, e.asid};
		cp0Regs_i.entryLo0 <= encodeLo(e.page0, e.isGlobal);
		cp0Regs_i.entryLo1 <= encodeLo(e.page1, e.isGlobal);
		// the unused slot register points elsewhere
		if (useRandom)
		begin
			cp0Regs_i.random <= slot;
			cp0Regs_i.index <= ~slot;
		end
		else
		begin
			cp0Regs_i.index <= slot;
			cp0Regs_i.random <= ~slot;
		end
		tlbwRandom_i <= useRandom;
		tlbwStrobe_i <= 1'b1;
		@(posedge clk);
		tlbwStrobe_i <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		checkEq("mcheck_o", expDup, mcheck_o);
		if (!expDup)
			shadow[slot] = stored;
	endtask

	task automatic readEntry(input int unsigned slot);
		@(posedge clk);
		cp0Regs_i.index <= slot;
		tlbrStrobe_i <= 1'b1;
		tlbrQ.push_back({shadow[slot].vpn2, 5'b0, shadow[slot].asid,
			encodeLo(shadow[slot].page0, shadow[slot].isGlobal),
			encodeLo(shadow[slot].page1, shadow[slot].isGlobal)});
		@(posedge clk);
		tlbrStrobe_i <= 1'b0;
		while (tlbrQ.size() != 0)
			@(negedge clk);
	endtask

	task automatic sendReq(input logic [31:0] va, input logic wr, input logic [`ASID_W-1:0] asid);
		@(posedge clk);
		xlatReq_i <= '{valid: 1'b1, vaddr: va, write: wr};
		cp0Regs_i.entryHi.asid <= asid;
		respQ.push_back(expectXlat(va, wr, asid));
	endtask

	task automatic flushReqs();
		@(posedge clk);
		xlatReq_i.valid <= 1'b0;
		while (respQ.size() != 0)
			@(negedge clk);
	endtask

	////////////////////
	// response monitor
	always @(negedge clk)
	begin
		if (rstN_i)
		begin
			if (i_dut.protocolChecks.violations != 0)
			begin
				$display("A bound protocol assertion on mmuTop failed");
				failRun();
			end
			if (xlatResp_o.valid)
			begin
				if (respQ.size() == 0)
				begin
					$display("Translation response arrived with no request outstanding");
					failRun();
				end
				expResp = respQ.pop_front();
				checkEq("xlatResp_o.paddr", expResp.paddr, xlatResp_o.paddr);
				checkEq("xlatResp_o.fault", expResp.fault, xlatResp_o.fault);
				checkEq("xlatResp_o.region", expResp.region, xlatResp_o.region);
				checkEq("xlatResp_o.asid", expResp.asid, xlatResp_o.asid);
			end
			if (tlbrData_o.valid)
			begin
				if (tlbrQ.size() == 0)
				begin
					$display("tlbr data arrived with no tlbr request outstanding");
					failRun();
				end
				expRd = tlbrQ.pop_front();
				checkEq("tlbrData_o.entryHi", expRd[95:64], tlbrData_o.entryHi);
				checkEq("tlbrData_o.entryLo0", expRd[63:32], tlbrData_o.entryLo0);
				checkEq("tlbrData_o.entryLo1", expRd[31:0], tlbrData_o.entryLo1);
			end
		end
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
			failRun();
		end
	end

	initial
	begin
		logic [`VPN2_W-1:0] vpnA;
		logic [`VPN2_W-1:0] vpnB;
		logic [`VPN2_W-1:0] vpnC;
		logic [`VPN2_W-1:0] vpnD;
		logic [31:0] va;
		tlbEntry_t e;
		int unsigned slot;
		rngState = 32'd42;
		// reset from time zero
		rstN_i <= 1'b0;
		cp0Regs_i = '0;
		tlbwStrobe_i = 1'b0;
		tlbwRandom_i = 1'b0;
		tlbrStrobe_i = 1'b0;
		xlatReq_i = '0;
		for (int i = 0; i < `TLB_ENTRIES; i++)
			shadow[i] = '0;
		repeat (5) @(posedge clk);
		rstN_i <= 1'b1;
		repeat (2) @(posedge clk);

		// distinct kuseg page pairs, vpnD never written
		va = nextRand();
		vpnA = {2'b00, va[16:2], 2'b00};
		vpnB = vpnA + 1;
		vpnC = vpnA + 2;
		vpnD = vpnA + 3;

		////////////////////
		// unmapped segments
		sendReq(32'h8000_0000 | (nextRand() & 32'h0FFF_FFFF), 1'b0, 8'h00);
		sendReq(32'hBFC0_0000 | (nextRand() & 32'h0000_0FFF), 1'b1, 8'h00);
		sendReq(32'hBFD0_03FC, 1'b0, 8'h00);
		sendReq(32'h9E00_0000 | (nextRand() & 32'h00FF_FFFF), 1'b0, 8'h00);
		sendReq(32'hB234_5678, 1'b0, 8'h00);
		flushReqs();

		////////////////////
		// indexed writes and mapped lookups
		e = '{present: 1'b1, vpn2: vpnA, asid: 8'h05, isGlobal: 1'b0,
			page0: makePage(20'(nextRand() & 32'h0FFFF), 1'b1, 1'b1),
			page1: makePage(`ROM_FRAME, 1'b1, 1'b1)};
		writeEntry(1'b0, 0, e);
		e = '{present: 1'b1, vpn2: vpnB, asid: 8'h05, isGlobal: 1'b1,
			page0: makePage(20'h1FD00, 1'b1, 1'b1),
			page1: makePage({`FLASH_TOP, 12'(nextRand())}, 1'b1, 1'b1)};
		writeEntry(1'b0, 1, e);
		e = '{present: 1'b1, vpn2: vpnC, asid: 8'h05, isGlobal: 1'b0,
			page0: makePage(20'(nextRand() & 32'h0FFFF), 1'b1, 1'b0),
			page1: makePage(20'(nextRand() & 32'h0FFFF), 1'b0, 1'b1)};
		writeEntry(1'b0, 2, e);

		sendReq({vpnA, 1'b0, 12'(nextRand())}, 1'b0, 8'h05);
		sendReq({vpnA, 1'b0, 12'(nextRand())}, 1'b1, 8'h05);
		sendReq({vpnA, 1'b1, 12'(nextRand())}, 1'b0, 8'h05);
		sendReq({vpnB, 1'b0, 12'h3F8}, 1'b1, 8'h05);
		sendReq({vpnB, 1'b0, 12'h3FC}, 1'b0, 8'h05);
		sendReq({vpnB, 1'b1, 12'(nextRand())}, 1'b0, 8'h05);
		flushReqs();

		// miss, ASID, invalid and clean-page cases
		sendReq({vpnD, 1'b0, 12'h010}, 1'b0, 8'h05);
		sendReq({vpnA, 1'b0, 12'h020}, 1'b0, 8'h06);
		sendReq({vpnB, 1'b1, 12'h030}, 1'b0, 8'h06);
		sendReq({vpnC, 1'b0, 12'h040}, 1'b0, 8'h05);
		sendReq({vpnC, 1'b1, 12'h050}, 1'b1, 8'h05);
		sendReq({vpnC, 1'b1, 12'h050}, 1'b0, 8'h05);
		flushReqs();

		////////////////////
		// duplicate key, then same-slot rewrite
		e = '{present: 1'b1, vpn2: vpnA, asid: 8'h05, isGlobal: 1'b0,
			page0: makePage(20'h00ABC, 1'b1, 1'b1),
			page1: makePage(20'h00ABD, 1'b0, 1'b1)};
		writeEntry(1'b0, 3, e);
		readEntry(3);
		writeEntry(1'b0, 0, e);
		readEntry(0);

		// random slot with random fields
		va = nextRand();
		slot = va[3:0];
		e.vpn2 = {2'b01, va[20:4]};
		e.asid = va[28:21];
		e.isGlobal = va[29];
		e.page0 = makePage(20'(nextRand()), va[30], va[31]);
		e.page0.cache = 3'(nextRand());
		e.page1 = makePage(20'(nextRand()), va[31], va[30]);
		e.page1.cache = 3'(nextRand());
		writeEntry(1'b1, slot, e);
		readEntry(slot);

		////////////////////
		// back-to-back requests
		for (int i = 0; i < 12; i++)
		begin
			va = nextRand();
			case (va[1:0])
				2'd0: sendReq({vpnA, va[12:0]}, va[2], va[3] ? 8'h05 : 8'h06);
				2'd1: sendReq({vpnB, va[12:0]}, va[2], va[3] ? 8'h05 : 8'h06);
				2'd2: sendReq({vpnC, va[12:0]}, va[2], 8'h05);
				default: sendReq({e.vpn2, va[12:0]}, va[2], va[3] ? e.asid : 8'h00);
			endcase
		end
		flushReqs();

		repeat (2) @(posedge clk);
		@(negedge clk);
		if (i_dut.protocolChecks.violations == 0)
		begin
			$display("Simulation completed successfully");
			$finish;
		end
		else
		begin
			$display("A bound protocol assertion on mmuTop failed");
			failRun();
		end
	end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/mmuTlbPkg.sv
verilog/mmuXlatPkg.sv
verilog/physRegionDecode.sv
verilog/tlbMatch.sv
verilog/tlbStore.sv
verilog/tlbWriteCtrl.sv
verilog/addrTranslate.sv
verilog/mmuTop.sv
test/mmuTop_sva.sv
test/mmuTop_tb.sv
